// ==== Bender.yml ====
package:
  name: snake_game

sources:
  - snake_pkg.sv
  - snake_head_step.sv
  - snake_body_shift.sv
  - snake_food_keeper.sv
  - snake_pixel_hit.sv
  - snake_game_top.sv
  - target: simulation
    files:
      - tb_snake_game.sv

// ==== files.f ====
snake_pkg.sv
snake_head_step.sv
snake_body_shift.sv
snake_food_keeper.sv
snake_pixel_hit.sv
snake_game_top.sv
tb_snake_game.sv

// ==== snake_body_shift.sv ====
`timescale 1ns/1ps

module snake_body_shift #(
    parameter int MAX_LEN = snake_pkg::MAX_LEN_DEFAULT
) (
    input  logic                              Clk_Snake,
    input  logic                              reset,
    input  snake_pkg::dir_t                   dir,
    input  snake_pkg::cell_pos_t              head,
    output snake_pkg::cell_pos_t [MAX_LEN-2:0] body
);
    import snake_pkg::*;

    logic frozen;

    // Game not started or already lost
    assign frozen = (dir == DIR_IDLE) || (dir == DIR_OVER);

    ////////////////////////////////////////////////////////////
    // Segment shift register
    ////////////////////////////////////////////////////////////

    // Segment 0 sits right behind the head, last index is the
    // tail. Codes 6 and 7 shift like a move even though the head
    // holds, so the body may fold onto the head there.
    always_ff @(posedge Clk_Snake or posedge reset) begin
        if (reset) begin
            body    <= '0;            // Unused segments at (0,0)
            body[0] <= BODY0_START;
            body[1] <= BODY1_START;
        end else if (!frozen) begin
            body <= {body[MAX_LEN-3:0], head};
        end
    end

endmodule

// ==== snake_food_keeper.sv ====
`timescale 1ns/1ps

module snake_food_keeper #(
    parameter int MAX_LEN = snake_pkg::MAX_LEN_DEFAULT
) (
    input  logic                   Clk_Snake,
    input  logic                   reset,
    input  snake_pkg::cell_pos_t   head,
    output snake_pkg::cell_pos_t   food,
    output snake_pkg::food_count_t food_count,
    output snake_pkg::len_t        len
);
    import snake_pkg::*;

    localparam coord_t LAST_X   = SCREEN_W - CELL;
    localparam coord_t LAST_Y   = SCREEN_H - CELL;
    localparam len_t   LEN_FULL = len_t'(MAX_LEN);

    cell_pos_t cnt;   // Next food cell
    logic      eat;

    assign eat = (head == food);

    ////////////////////////////////////////////////////////////
    // Placement counter
    ////////////////////////////////////////////////////////////

    // Runs every clock, x forward and y backward, so the food
    // lands on a cell that depends on when it was eaten
    always_ff @(posedge Clk_Snake or posedge reset) begin
        if (reset) begin
            cnt <= COUNT_START;
        end else begin
            cnt.x <= (cnt.x == LAST_X) ? '0 : cnt.x + CELL;
            cnt.y <= (cnt.y == '0) ? LAST_Y : cnt.y - CELL;
        end
    end

    ////////////////////////////////////////////////////////////
    // Eating and growth
    ////////////////////////////////////////////////////////////

    always_ff @(posedge Clk_Snake or posedge reset) begin
        if (reset) begin
            food       <= FOOD_START;
            food_count <= '0;
            len        <= START_LEN;
        end else if (eat) begin
            food       <= cnt;
            food_count <= food_count + 1'b1;
            if (len != LEN_FULL)
                len <= len + 1'b1;   // Saturates at MAX_LEN
        end
    end

endmodule

// ==== snake_game_top.sv ====
`timescale 1ns/1ps

module snake_game_top #(
    parameter int MAX_LEN = snake_pkg::MAX_LEN_DEFAULT
) (
    input  logic                   Clk_Snake,
    input  logic                   reset,
    input  snake_pkg::coord_t      sx,
    input  snake_pkg::coord_t      sy,
    input  snake_pkg::dir_t        dir,
    output logic                   head_draw,
    output logic                   snake_draw,
    output logic                   collide,
    output logic                   food_draw,
    output snake_pkg::food_count_t food_count
);
    import snake_pkg::*;

    cell_pos_t                head;
    cell_pos_t [MAX_LEN-2:0]  body;
    cell_pos_t                food;
    cell_pos_t                pix;    // Current scan pixel
    len_t                     len;

    assign pix = '{x: sx, y: sy};

    ////////////////////////////////////////////////////////////
    // Position producers
    ////////////////////////////////////////////////////////////

    snake_head_step u_head_step (
        .Clk_Snake (Clk_Snake),
        .reset     (reset),
        .dir       (dir),
        .head      (head)
    );

    snake_food_keeper #(
        .MAX_LEN (MAX_LEN)
    ) u_food_keeper (
        .Clk_Snake  (Clk_Snake),
        .reset      (reset),
        .head       (head),
        .food       (food),
        .food_count (food_count),
        .len        (len)
    );

    snake_body_shift #(
        .MAX_LEN (MAX_LEN)
    ) u_body_shift (
        .Clk_Snake (Clk_Snake),
        .reset     (reset),
        .dir       (dir),
        .head      (head),
        .body      (body)
    );

    ////////////////////////////////////////////////////////////
    // Pixel and collision tests
    ////////////////////////////////////////////////////////////

    snake_pixel_hit #(
        .MAX_LEN (MAX_LEN)
    ) u_pixel_hit (
        .pix        (pix),
        .head       (head),
        .body       (body),
        .food       (food),
        .len        (len),
        .head_draw  (head_draw),
        .snake_draw (snake_draw),
        .collide    (collide),
        .food_draw  (food_draw)
    );

endmodule

// ==== snake_head_step.sv ====
`timescale 1ns/1ps

module snake_head_step (
    input  logic                 Clk_Snake,
    input  logic                 reset,
    input  snake_pkg::dir_t      dir,
    output snake_pkg::cell_pos_t head
);
    import snake_pkg::*;

    localparam coord_t LAST_X = SCREEN_W - CELL;   // Rightmost cell corner
    localparam coord_t LAST_Y = SCREEN_H - CELL;   // Bottom cell corner

    ////////////////////////////////////////////////////////////
    // Head motion, one cell per clock
    ////////////////////////////////////////////////////////////

    always_ff @(posedge Clk_Snake or posedge reset) begin
        if (reset) begin
            head <= HEAD_START;
        end else begin
            case (dir)
                DIR_UP: begin
                    if (head.y == '0)
                        head.y <= LAST_Y;   // Wrap to bottom
                    else
                        head.y <= head.y - CELL;
                end
                DIR_DOWN: begin
                    if (head.y == LAST_Y)
                        head.y <= '0;
                    else
                        head.y <= head.y + CELL;
                end
                DIR_LEFT: begin
                    if (head.x == '0)
                        head.x <= LAST_X;   // Wrap to right edge
                    else
                        head.x <= head.x - CELL;
                end
                DIR_RIGHT: begin
                    if (head.x == LAST_X)
                        head.x <= '0;
                    else
                        head.x <= head.x + CELL;
                end
                default: begin
                    // Idle, game over and unused codes hold
                    head <= head;
                end
            endcase
        end
    end

endmodule

// ==== snake_pixel_hit.sv ====
`timescale 1ns/1ps

module snake_pixel_hit #(
    parameter int MAX_LEN = snake_pkg::MAX_LEN_DEFAULT
) (
    input  snake_pkg::cell_pos_t               pix,
    input  snake_pkg::cell_pos_t               head,
    input  snake_pkg::cell_pos_t [MAX_LEN-2:0] body,
    input  snake_pkg::cell_pos_t               food,
    input  snake_pkg::len_t                    len,
    output logic                               head_draw,
    output logic                               snake_draw,
    output logic                               collide,
    output logic                               food_draw
);
    import snake_pkg::*;

    logic [MAX_LEN-2:0] seg_live;   // Segment inside current length
    logic [MAX_LEN-2:0] seg_hit;
    logic [MAX_LEN-2:0] seg_bite;

    // Strictly inside the cell, so the grid lines stay dark
    function automatic logic cell_hit(input cell_pos_t p, input cell_pos_t c);
        logic in_x;
        logic in_y;
        in_x = (p.x > c.x) && (p.x < c.x + CELL);
        in_y = (p.y > c.y) && (p.y < c.y + CELL);
        return in_x && in_y;
    endfunction

    ////////////////////////////////////////////////////////////
    // Per-segment tests
    ////////////////////////////////////////////////////////////

    // Length counts the head, so segments 0 to len-2 are live
    always_comb begin
        for (int i = 0; i < MAX_LEN - 1; i++) begin
            seg_live[i] = (i + 1) < int'(len);
            seg_hit[i]  = seg_live[i] && cell_hit(pix, body[i]);
            seg_bite[i] = seg_live[i] && (head == body[i]);
        end
    end

    ////////////////////////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////////////////////////

    assign head_draw  = cell_hit(pix, head);
    assign food_draw  = cell_hit(pix, food);
    assign snake_draw = |seg_hit;

    assign collide = (len >= COLLIDE_MIN_LEN) && (|seg_bite);

endmodule

// ==== snake_pkg.sv ====
package snake_pkg;

    ////////////////////////////////////////////////////////////
    // Grid geometry
    ////////////////////////////////////////////////////////////

    typedef logic [9:0] coord_t;      // Pixel coordinate, x or y

    // Top-left corner of a grid cell
    typedef struct packed {
        coord_t x;
        coord_t y;
    } cell_pos_t;

    localparam coord_t CELL     = 10'd32;
    localparam coord_t SCREEN_W = 10'd640;
    localparam coord_t SCREEN_H = 10'd480;

    ////////////////////////////////////////////////////////////
    // Game state types
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        DIR_IDLE  = 3'd0,
        DIR_UP    = 3'd1,
        DIR_DOWN  = 3'd2,
        DIR_LEFT  = 3'd3,
        DIR_RIGHT = 3'd4,
        DIR_OVER  = 3'd5
    } dir_t;

    typedef logic [7:0] food_count_t;   // Wraps at 256

    localparam int MAX_LEN_DEFAULT = 15;
    typedef logic [$clog2(MAX_LEN_DEFAULT + 1)-1:0] len_t;

    // Start positions
    localparam cell_pos_t HEAD_START  = '{x: 10'd288, y: 10'd224};
    localparam cell_pos_t BODY0_START = '{x: 10'd256, y: 10'd224};
    localparam cell_pos_t BODY1_START = '{x: 10'd224, y: 10'd224};
    localparam cell_pos_t FOOD_START  = '{x: 10'd416, y: 10'd160};
    localparam cell_pos_t COUNT_START = '{x: 10'd0,   y: 10'd448};

    localparam len_t START_LEN       = 4'd3;
    localparam len_t COLLIDE_MIN_LEN = 4'd5;   // Shorter snakes cannot bite themselves

endpackage

// ==== tb_snake_game.sv ====
`timescale 1ns/1ps

module tb_snake_game;
    import snake_pkg::*;

    localparam int MAX_LEN     = 15;
    localparam int CLK_PERIOD  = 4;
    localparam int STEER_LIMIT = 200;
    // Reset, motion, freeze, steering, collision, random walk, final check
    localparam int STIM_CYCLES = 10 + 21 + 8 + STEER_LIMIT + 5 + 400 + 1;

    logic        Clk_Snake;
    logic        reset;
    coord_t      sx;
    coord_t      sy;
    dir_t        dir;
    logic        head_draw;
    logic        snake_draw;
    logic        collide;
    logic        food_draw;
    food_count_t food_count;

    // Reference model state
    cell_pos_t   m_head;
    cell_pos_t   m_body [0:MAX_LEN-2];
    cell_pos_t   m_food;
    cell_pos_t   m_cnt;
    int          m_len;
    logic [7:0]  m_fc;

    cell_pos_t   cur_pix;       // Pixel currently on sx/sy
    logic        hold_rst;
    logic [31:0] rng_state;
    int          probe_k;

    snake_game_top #(
        .MAX_LEN (MAX_LEN)
    ) u_dut (
        .Clk_Snake  (Clk_Snake),
        .reset      (reset),
        .sx         (sx),
        .sy         (sy),
        .dir        (dir),
        .head_draw  (head_draw),
        .snake_draw (snake_draw),
        .collide    (collide),
        .food_draw  (food_draw),
        .food_count (food_count)
    );

    initial begin
        Clk_Snake = 1'b0;
        forever #(CLK_PERIOD / 2) Clk_Snake = ~Clk_Snake;
    end

    initial begin
        #(2 * STIM_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the stimulus finished");
        $display("Test FAILED");
        $fatal(1);
    end

    ////////////////////////////////////////////////////////////
    // Failure reporting and random numbers
    ////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string name, input logic [31:0] e,
                                   input logic [31:0] g);
        $display("FAILED %s exp %h got %h", name, e, g);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic stop_with(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1);
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    task automatic next_rand(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r = rng_state;
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic cell_pos_t next_head(input cell_pos_t h, input dir_t d);
        cell_pos_t n;
        n = h;
        case (d)
            DIR_UP:    n.y = (h.y == 10'd0)   ? 10'd448 : h.y - 10'd32;
            DIR_DOWN:  n.y = (h.y == 10'd448) ? 10'd0   : h.y + 10'd32;
            DIR_LEFT:  n.x = (h.x == 10'd0)   ? 10'd608 : h.x - 10'd32;
            DIR_RIGHT: n.x = (h.x == 10'd608) ? 10'd0   : h.x + 10'd32;
            default:   n = h;
        endcase
        return n;
    endfunction

    function automatic logic inside_cell(input cell_pos_t p, input cell_pos_t c);
        return (int'(p.x) > int'(c.x)) && (int'(p.x) < int'(c.x) + 32) &&
               (int'(p.y) > int'(c.y)) && (int'(p.y) < int'(c.y) + 32);
    endfunction

    task automatic model_reset();
        m_head = '{x: 10'd288, y: 10'd224};
        m_food = '{x: 10'd416, y: 10'd160};
        m_cnt  = '{x: 10'd0,   y: 10'd448};
        m_len  = 3;
        m_fc   = 8'd0;
        for (int i = 0; i < MAX_LEN - 1; i++)
            m_body[i] = '{x: 10'd0, y: 10'd0};
        m_body[0] = '{x: 10'd256, y: 10'd224};
        m_body[1] = '{x: 10'd224, y: 10'd224};
    endtask

    task automatic model_advance(input dir_t d);
        logic      eat;
        cell_pos_t old_cnt;
        eat     = (m_head == m_food);
        old_cnt = m_cnt;
        if (d != DIR_IDLE && d != DIR_OVER) begin
            for (int i = MAX_LEN - 2; i > 0; i--)
                m_body[i] = m_body[i-1];
            m_body[0] = m_head;
        end
        m_head  = next_head(m_head, d);
        m_cnt.x = (m_cnt.x == 10'd608) ? 10'd0 : m_cnt.x + 10'd32;
        m_cnt.y = (m_cnt.y == 10'd0) ? 10'd448 : m_cnt.y - 10'd32;
        if (eat) begin
            m_food = old_cnt;
            m_fc   = m_fc + 8'd1;
            if (m_len < MAX_LEN)
                m_len++;
        end
    endtask

    task automatic check_outputs();
        logic e_head;
        logic e_snake;
        logic e_food;
        logic e_coll;
        e_head  = inside_cell(cur_pix, m_head);
        e_food  = inside_cell(cur_pix, m_food);
        e_snake = 1'b0;
        e_coll  = 1'b0;
        for (int i = 0; i < m_len - 1; i++) begin
            e_snake = e_snake | inside_cell(cur_pix, m_body[i]);
            e_coll  = e_coll | (m_head == m_body[i]);
        end
        e_coll = e_coll && (m_len >= 5);   // Too short to bite itself
        assert (head_draw === e_head)
            else report_mismatch("head_draw", 32'(e_head), 32'(head_draw));
        assert (snake_draw === e_snake)
            else report_mismatch("snake_draw", 32'(e_snake), 32'(snake_draw));
        assert (food_draw === e_food)
            else report_mismatch("food_draw", 32'(e_food), 32'(food_draw));
        assert (collide === e_coll)
            else report_mismatch("collide", 32'(e_coll), 32'(collide));
        assert (food_count === m_fc)
            else report_mismatch("food_count", 32'(m_fc), 32'(food_count));
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    // Centers and corners of cells as they stand after the next edge
    function automatic cell_pos_t probe_pick(input int mode, input dir_t d,
                                             input logic [31:0] r);
        cell_pos_t c;
        case (mode)
            0: c = next_head(m_head, d);
            1: c = m_head;
            2: c = m_body[m_len-3];
            3: c = (m_head == m_food) ? m_cnt : m_food;
            4: return next_head(m_head, d);   // Exact corner, never lit
            default: return '{x: 10'(r % 640), y: 10'((r >> 12) % 480)};
        endcase
        return '{x: c.x + 10'd16, y: c.y + 10'd16};
    endfunction

    // Check the settled outputs, then drive the next cycle
    task automatic step(input dir_t d, input cell_pos_t p);
        @(negedge Clk_Snake);
        check_outputs();
        reset   = hold_rst;
        dir     = d;
        sx      = p.x;
        sy      = p.y;
        cur_pix = p;
        @(posedge Clk_Snake);
        if (!hold_rst)
            model_advance(d);
    endtask

    task automatic move(input dir_t d, input int mode);
        logic [31:0] r;
        next_rand(r);
        step(d, probe_pick(mode, d, r));
    endtask

    task automatic walk(input dir_t d, input int n);
        for (int i = 0; i < n; i++) begin
            move(d, probe_k % 6);
            probe_k++;
        end
    endtask

    initial begin
        cell_pos_t   rst_probe [0:9];
        logic [31:0] r;
        int          guard;
        reset       = 1'b1;
        dir         = DIR_IDLE;
        sx          = '0;
        sy          = '0;
        cur_pix     = '0;
        hold_rst    = 1'b1;
        rng_state   = 32'hf132184e;
        probe_k     = 0;
        model_reset();

        rst_probe = '{'{x: 10'd304, y: 10'd240}, '{x: 10'd272, y: 10'd240},
                      '{x: 10'd240, y: 10'd240}, '{x: 10'd432, y: 10'd176},
                      '{x: 10'd288, y: 10'd224}, '{x: 10'd416, y: 10'd160},
                      '{x: 10'd16,  y: 10'd16},  '{x: 10'd256, y: 10'd224},
                      '{x: 10'd319, y: 10'd255}, '{x: 10'd320, y: 10'd240}};
        foreach (rst_probe[i])
            step(DIR_IDLE, rst_probe[i]);
        hold_rst = 1'b0;

        walk(DIR_RIGHT, 12);    // Wraps 608 to 0
        walk(DIR_UP, 9);        // Wraps 0 to 448
        walk(DIR_IDLE, 4);
        walk(DIR_OVER, 4);

        // Chase the food until the snake is long enough to bite itself
        guard = 0;
        while (m_len < 5) begin
            if (guard == STEER_LIMIT) begin
                stop_with("Snake did not reach the food in time");
            end else begin
                walk((m_head.x != m_food.x) ? DIR_RIGHT : DIR_UP, 1);
                guard++;
            end
        end

        // Tight loop so the head comes back onto segment 3
        walk(DIR_UP, 1);
        walk(DIR_LEFT, 1);
        walk(DIR_DOWN, 1);
        walk(DIR_RIGHT, 1);
        walk(DIR_OVER, 1);

        for (int i = 0; i < 400; i++) begin
            next_rand(r);
            move(dir_t'(3'd1 + 3'(r % 4)), int'((r >> 8) % 6));
        end

        @(negedge Clk_Snake);
        check_outputs();
        $display("Test OK");
        $finish;
    end

endmodule
